//--- design/div_pkg.sv
package div_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int DIV_W       = 16;  // Operand width
  localparam int COUNT_W     = 5;   // Holds 0 to DIV_W
  localparam int RSP_CREDITS = 2;   // Most egress credits a consumer may grant
  localparam int CREDIT_W    = $clog2(RSP_CREDITS + 1);

  typedef logic [DIV_W-1:0]    operand_t;
  typedef logic [COUNT_W-1:0]  count_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  //////////////////////////////
  // Request and response
  //////////////////////////////

  typedef struct packed {
    operand_t dividend;
    operand_t divisor;
  } div_req_t;

  typedef struct packed {
    operand_t quotient;
    operand_t remainder;
    logic     div_by_zero;
  } div_rsp_t;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_START,
    ST_SHIFT_DEC,
    ST_CHECK,
    ST_ADD,
    ST_END
  } ctl_state_t;

endpackage

//--- design/div_flow.sv
`timescale 1ns/1ps

module div_flow
  import div_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic rsp_credit,
  input  logic send,
  output logic have_credit,
  output logic req_credit
);

  credit_t credit_q;
  logic    boot_q;

  //////////////////////////////
  // Egress credits
  //////////////////////////////

  // Grant and spend may land in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q <= '0;
    end else begin
      case ({rsp_credit, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign have_credit = (credit_q != '0);

  //////////////////////////////
  // Ingress credit
  //////////////////////////////

  // Single ingress credit, returned once the result has gone out
  always_ff @(posedge clk) begin
    if (rst) begin
      boot_q     <= 1'b1;
      req_credit <= 1'b0;
    end else begin
      boot_q     <= 1'b0;
      req_credit <= boot_q | send;  // First grant follows reset
    end
  end

endmodule

//--- design/div_ctl.sv
`timescale 1ns/1ps

module div_ctl
  import div_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  logic       diff_neg,
  input  logic       last,
  input  logic       have_credit,
  output logic       init,
  output logic       sh,
  output logic       dec,
  output logic       lda,
  output logic       send,
  output ctl_state_t state
);

  ctl_state_t state_nxt;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_START;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_START: begin
        if (req_valid) begin
          state_nxt = ST_SHIFT_DEC;
        end
      end
      ST_SHIFT_DEC: begin
        state_nxt = ST_CHECK;
      end
      ST_CHECK: begin
        // A failed trial on the last bit ends the division here
        if (!diff_neg) begin
          state_nxt = ST_ADD;
        end else if (last) begin
          state_nxt = ST_END;
        end else begin
          state_nxt = ST_SHIFT_DEC;
        end
      end
      ST_ADD: begin
        state_nxt = last ? ST_END : ST_SHIFT_DEC;
      end
      ST_END: begin
        if (have_credit) begin
          state_nxt = ST_START;  // Response leaves this cycle
        end
      end
      default: begin
        state_nxt = ST_START;
      end
    endcase
  end

  //////////////////////////////
  // Datapath strobes
  //////////////////////////////

  always_comb begin
    init = 1'b0;
    sh   = 1'b0;
    dec  = 1'b0;
    lda  = 1'b0;
    send = 1'b0;
    case (state)
      ST_START: begin
        init = req_valid;  // Capture operands with the request
      end
      ST_SHIFT_DEC: begin
        sh  = 1'b1;
        dec = 1'b1;
      end
      ST_ADD: begin
        lda = 1'b1;
      end
      ST_END: begin
        send = have_credit;
      end
      default: begin
        init = 1'b0;
      end
    endcase
  end

endmodule

//--- design/div_datapath.sv
`timescale 1ns/1ps

module div_datapath
  import div_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  div_req_t req,
  input  logic     init,
  input  logic     sh,
  input  logic     dec,
  input  logic     lda,
  input  logic     send,
  output logic     diff_neg,
  output logic     last,
  output div_rsp_t rsp
);

  logic [DIV_W:0]   rem_q;   // Extra bit for the bit shifted in from the quotient
  operand_t         quo_q;   // Dividend on load, quotient bits fill from the right
  operand_t         dvs_q;
  count_t           cnt_q;
  logic             dbz_q;
  logic [DIV_W+1:0] diff;

  //////////////////////////////
  // Iteration counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (init) begin
      cnt_q <= count_t'(DIV_W);
    end else if (dec) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last = (cnt_q == '0);

  //////////////////////////////
  // Trial subtraction
  //////////////////////////////

  // Sign bit of the wide difference tells whether the divisor fits
  assign diff     = {1'b0, rem_q} - {2'b00, dvs_q};
  assign diff_neg = diff[DIV_W+1];

  //////////////////////////////
  // Operand registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (init) begin
      dvs_q <= req.divisor;
      quo_q <= req.dividend;
      rem_q <= '0;
    end else if (sh) begin
      rem_q <= {rem_q[DIV_W-1:0], quo_q[DIV_W-1]};
      quo_q <= {quo_q[DIV_W-2:0], 1'b0};
    end else if (lda) begin
      rem_q    <= diff[DIV_W:0];  // Keep the difference
      quo_q[0] <= 1'b1;
    end
  end

  // With a zero divisor every trial passes, which gives all ones and
  // leaves the dividend in the remainder
  always_ff @(posedge clk) begin
    if (rst) begin
      dbz_q <= 1'b0;
    end else if (init) begin
      dbz_q <= (req.divisor == '0);
    end else if (send) begin
      dbz_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_comb begin
    rsp.quotient    = quo_q;
    rsp.remainder   = rem_q[DIV_W-1:0];  // Top bit is clear once finished
    rsp.div_by_zero = dbz_q;
  end

endmodule

//--- design/div_top.sv
`timescale 1ns/1ps

module div_top
  import div_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  div_req_t req,
  output logic     req_credit,
  output logic     rsp_valid,
  output div_rsp_t rsp,
  input  logic     rsp_credit
);

  logic       init;
  logic       sh;
  logic       dec;
  logic       lda;
  logic       diff_neg;
  logic       last;
  logic       have_credit;
  ctl_state_t state;  // Observed by the bound checks

  //////////////////////////////
  // Flow control
  //////////////////////////////

  div_flow u_div_flow (
    .clk         (clk),
    .rst         (rst),
    .rsp_credit  (rsp_credit),
    .send        (rsp_valid),
    .have_credit (have_credit),
    .req_credit  (req_credit)
  );

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  div_ctl u_div_ctl (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .diff_neg    (diff_neg),
    .last        (last),
    .have_credit (have_credit),
    .init        (init),
    .sh          (sh),
    .dec         (dec),
    .lda         (lda),
    .send        (rsp_valid),  // Send is the response strobe
    .state       (state)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  div_datapath u_div_datapath (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .init     (init),
    .sh       (sh),
    .dec      (dec),
    .lda      (lda),
    .send     (rsp_valid),
    .diff_neg (diff_neg),
    .last     (last),
    .rsp      (rsp)
  );

endmodule

//--- tb/div_top_props.sv
`timescale 1ns/1ps

module div_top_props
  import div_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       req_valid,
  input logic       req_credit,
  input logic       rsp_valid,
  input logic       rsp_credit,
  input ctl_state_t state
);

  int fail_count = 0;
  int credits_held;  // Egress grants not yet spent

  //////////////////////////////
  // Egress handshake
  //////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      credits_held <= 0;
    end else begin
      credits_held <= credits_held + int'(rsp_credit) - int'(rsp_valid);
    end
  end

  rsp_needs_credit: assert property (
    @(posedge clk) disable iff (rst) rsp_valid |-> (credits_held > 0)
  ) else begin
    fail_count++;
    $error("rsp_valid while no egress credit is held");
  end

  rsp_single_cycle: assert property (
    @(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid
  ) else begin
    fail_count++;
    $error("rsp_valid held for more than one cycle");
  end

  //////////////////////////////
  // Ingress handshake
  //////////////////////////////

  // One ingress credit means a request never meets a busy sequencer
  req_in_start: assert property (
    @(posedge clk) disable iff (rst) req_valid |-> (state == ST_START)
  ) else begin
    fail_count++;
    $error("req_valid outside ST_START");
  end

  req_credit_pulse: assert property (
    @(posedge clk) disable iff (rst) req_credit |=> !req_credit
  ) else begin
    fail_count++;
    $error("req_credit high two cycles in a row");
  end

endmodule

bind div_top div_top_props u_div_top_props (
  .clk        (clk),
  .rst        (rst),
  .req_valid  (req_valid),
  .req_credit (req_credit),
  .rsp_valid  (rsp_valid),
  .rsp_credit (rsp_credit),
  .state      (state)
);

//--- tb/div_tb.sv
`timescale 1ns/1ps

module div_tb
  import div_pkg::*;
();

  localparam int NUM_RANDOM     = 200;
  localparam int NUM_DIVS       = NUM_RANDOM + 20;
  localparam int MAX_DIV_CYCLES = 60;
  localparam int BP_SLACK       = 6800;  // Back-pressure holds and idle gaps
  localparam int TIMEOUT_CYCLES = NUM_DIVS * MAX_DIV_CYCLES + BP_SLACK;
  localparam int RSP_WAIT       = 200;
  localparam int BP_HOLD        = 100;

  logic        clk;
  logic        rst;
  logic        req_valid;
  div_req_t    req;
  logic        req_credit;
  logic        rsp_valid;
  div_rsp_t    rsp;
  logic        rsp_credit;

  int          errors;
  int          cycle_cnt;
  int          credits_got;    // Ingress credits seen
  int          credits_spent;  // Requests sent
  div_rsp_t    rsp_q[$];
  logic [31:0] lcg_state;

  div_top u_div_top (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  always #4 clk = ~clk;

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (req_credit) begin
        credits_got++;
      end
      if (rsp_valid) begin
        rsp_q.push_back(rsp);
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic operand_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic div_rsp_t expected_rsp(operand_t a, operand_t b);
    div_rsp_t r;
    if (b == '0) begin
      r.quotient    = '1;
      r.remainder   = a;
      r.div_by_zero = 1'b1;
    end else begin
      r.quotient    = a / b;
      r.remainder   = a % b;
      r.div_by_zero = 1'b0;
    end
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic give_rsp_credit();
    rsp_credit = 1'b1;
    next_cycle();
    rsp_credit = 1'b0;
  endtask

  task automatic send_request(operand_t a, operand_t b);
    int waited;
    waited = 0;
    while (credits_got == credits_spent && waited < RSP_WAIT) begin
      next_cycle();
      waited++;
    end
    if (credits_got == credits_spent) begin
      $display("No ingress credit to send %h / %h", a, b);
      errors++;
      return;
    end
    credits_spent++;
    req_valid    = 1'b1;
    req.dividend = a;
    req.divisor  = b;
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic expect_response(operand_t a, operand_t b);
    div_rsp_t exp;
    div_rsp_t got;
    int       waited;
    exp    = expected_rsp(a, b);
    waited = 0;
    while (rsp_q.size() == 0 && waited < RSP_WAIT) begin
      next_cycle();
      waited++;
    end
    if (rsp_q.size() == 0) begin
      $display("No response for %h / %h within %0d cycles", a, b, RSP_WAIT);
      errors++;
      return;
    end
    got = rsp_q.pop_front();
    if (got.quotient !== exp.quotient) begin
      $display("[ERROR] rsp.quotient got %h expected %h (%h / %h)",
               got.quotient, exp.quotient, a, b);
      errors++;
    end
    if (got.remainder !== exp.remainder) begin
      $display("[ERROR] rsp.remainder got %h expected %h (%h / %h)",
               got.remainder, exp.remainder, a, b);
      errors++;
    end
    if (got.div_by_zero !== exp.div_by_zero) begin
      $display("[ERROR] rsp.div_by_zero got %h expected %h (%h / %h)",
               got.div_by_zero, exp.div_by_zero, a, b);
      errors++;
    end
  endtask

  task automatic expect_ingress_credit();
    int waited;
    waited = 0;
    while (credits_got == credits_spent && waited < 4) begin
      next_cycle();
      waited++;
    end
    if (credits_got == credits_spent) begin
      $display("No ingress credit followed the response");
      errors++;
    end
  endtask

  task automatic run_division(operand_t a, operand_t b);
    give_rsp_credit();
    send_request(a, b);
    expect_response(a, b);
    expect_ingress_credit();
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    repeat (10) next_cycle();
    if (credits_got != 1) begin
      $display("Expected one ingress credit after reset, saw %0d", credits_got);
      errors++;
    end
    if (rsp_q.size() != 0) begin
      $display("Response appeared after reset without a request");
      errors++;
    end
  endtask

  task automatic test_directed();
    run_division(16'd100, 16'd7);
    run_division(16'd65535, 16'd1);
    run_division(16'd5, 16'd9);
    run_division(16'd65535, 16'd65535);
    run_division(16'd0, 16'd3);
  endtask

  task automatic test_div_by_zero();
    run_division(16'h1234, 16'h0000);
    run_division(16'h0000, 16'h0000);
    run_division(16'hffff, 16'h0000);
  endtask

  task automatic test_random();
    operand_t a;
    operand_t b;
    operand_t sel;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a   = lcg_next();
      b   = lcg_next();
      sel = lcg_next();
      b   = b >> sel[3:0];  // Spread the divisor sizes
      if (b == '0) begin
        b = 16'd1;
      end
      run_division(a, b);
    end
  endtask

  task automatic test_back_pressure();
    send_request(16'd5000, 16'd37);
    repeat (BP_HOLD) next_cycle();
    if (rsp_q.size() != 0) begin
      $display("Response sent with no egress credit granted");
      errors++;
      rsp_q.delete();
    end
    if (credits_got != credits_spent) begin
      $display("Ingress credit issued while the result was held");
      errors++;
    end
    give_rsp_credit();
    expect_response(16'd5000, 16'd37);
    expect_ingress_credit();
    repeat (20) next_cycle();
    if (rsp_q.size() != 0) begin
      $display("More than one response for a single egress credit");
      errors++;
      rsp_q.delete();
    end
  endtask

  task automatic test_credit_accounting();
    repeat (RSP_CREDITS) give_rsp_credit();
    send_request(16'd40000, 16'd123);
    expect_response(16'd40000, 16'd123);
    send_request(16'd777, 16'd778);
    expect_response(16'd777, 16'd778);
    send_request(16'd9999, 16'd10);
    repeat (BP_HOLD) next_cycle();
    if (rsp_q.size() != 0) begin
      $display("Third response sent after the granted credits were used");
      errors++;
      rsp_q.delete();
    end
    give_rsp_credit();
    expect_response(16'd9999, 16'd10);
    expect_ingress_credit();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    rsp_credit    = 1'b0;
    errors        = 0;
    credits_got   = 0;
    credits_spent = 0;
    lcg_state     = 32'hcb5b;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_directed();
    test_div_by_zero();
    test_random();
    test_back_pressure();
    test_credit_accounting();
    repeat (5) next_cycle();
    $display("Errors: %0d in checks, %0d in assertions",
             errors, u_div_top.u_div_top_props.fail_count);
    if (errors == 0 && u_div_top.u_div_top_props.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles without finishing", cycle_cnt);
    $display("Errors: %0d in checks, %0d in assertions",
             errors + 1, u_div_top.u_div_top_props.fail_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- project.f
design/div_pkg.sv
design/div_flow.sv
design/div_ctl.sv
design/div_datapath.sv
design/div_top.sv
tb/div_top_props.sv
tb/div_tb.sv
